//--- irDecode.f
source/irPkg.sv
source/instrLatch.sv
source/dispatchRam.sv
source/adCondition.sv
source/diagPort.sv
source/irTop.sv
verif/irTb.sv

//--- source/adCondition.sv
`timescale 1ns/1ps
`default_nettype none

module adCondition import irPkg::*; (
  input  wire adWordT    ad,
  input  wire            adCarry,
  input  wire [0:1]      magic,
  input  wire [0:2]      dramB,
  output logic           adEq0,
  output logic           aGtB,
  output logic           testSatisfied,
  output normT           norm
);

  logic magicEq;

  assign adEq0 = ~|ad;

  // Sign against the upper guard bit
  assign aGtB = ad[0] ^ ad[-2];

  assign magicEq = ~(magic[0] ^ magic[1]);

  // B bit 0 inverts the sense of the skip
  assign testSatisfied = (
    (dramB[1] & adEq0) |
    (dramB[2] & aGtB & magic[0]) |
    (dramB[2] & ad[0] & magic[1]) |
    (magicEq & adCarry)
  ) ^ dramB[0];

  // Normalize priority encoder
  always_comb begin
    if (ad[0]) begin
      norm = 3'd1;
    end else if (|ad[1:6]) begin
      norm = 3'd2;
    end else if (ad[7]) begin
      norm = 3'd3;
    end else if (ad[8]) begin
      norm = 3'd4;
    end else if (ad[9]) begin
      norm = 3'd5;
    end else if (ad[10]) begin
      norm = 3'd6;
    end else if (|ad[11:35]) begin
      norm = 3'd7;
    end else begin
      norm = 3'd0;
    end
  end

endmodule

`default_nettype wire

//--- source/diagPort.sv
`timescale 1ns/1ps
`default_nettype none

module diagPort import irPkg::*; (
  input  wire         eboxClk,
  input  wire         rstN,
  input  wire         wbCyc,
  input  wire         wbStb,
  input  wire         wbWe,
  input  wire [9:0]   wbAdr,
  input  wire [14:0]  wbDatW,
  input  wire         hostGrant,
  input  wire dramWordT hostRData,
  input  wire normT   norm,
  input  wire dramAddrT dramAddr,
  input  wire acT     irAc,
  input  wire [0:2]   dramA,
  input  wire [0:2]   dramB,
  input  wire [0:7]   dramJ,
  input  wire         dramOddParity,
  input  wire         testSatisfied,
  input  wire         jrst0,
  input  wire         isJrst,
  input  wire         adEq0,
  input  wire         ioLegal,
  input  wire         acEq0,
  input  wire         aGtB,
  input  wire         adCarry,
  output logic [14:0] wbDatR,
  output logic        wbAck,
  output hostReqT     host,
  output irEnablesT   enables
);

  typedef enum logic {idle, waitGrant} stateT;

  stateT     state;
  logic      reqQ;
  logic      weQ;
  dramAddrT  addrQ;
  dramWordT  wdataQ;
  logic      ramSel;
  logic      groupSel;
  logic      enSel;
  logic      start;
  diagSelT   groupNum;
  diagGroupT group;

  assign ramSel = (wbAdr < diagBase);
  assign groupSel = (wbAdr[9:3] == diagBase[9:3]);
  assign enSel = (wbAdr == enableReg);

  // A held strobe is not restarted while its ack is out
  assign start = wbCyc && wbStb && !wbAck;

  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      state <= idle;
      wbAck <= 1'b0;
      reqQ <= 1'b0;
      enables <= '0;
    end else begin
      wbAck <= 1'b0;
      case (state)
        idle: begin
          if (start && ramSel) begin
            reqQ <= 1'b1;
            state <= waitGrant;
          end else if (start) begin
            wbAck <= 1'b1;
            if (wbWe && enSel) begin
              enables <= irEnablesT'(wbDatW[1:0]);
            end
          end
        end
        waitGrant: begin
          if (hostGrant) begin
            reqQ <= 1'b0;
            wbAck <= 1'b1;
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Request payload
  always_ff @(posedge eboxClk) begin
    if (state == idle && start && ramSel) begin
      weQ <= wbWe;
      addrQ <= wbAdr[8:0];
      wdataQ <= dramWordT'(wbDatW);
    end
  end

  assign host = '{req: reqQ, we: weQ, addr: addrQ, wdata: wdataQ};

  assign groupNum = diagSelT'(wbAdr[2:0]);

  always_comb begin
    case (groupNum)
      3'd0: group = {norm, dramAddr[0:2]};
      3'd1: group = dramAddr[3:8];
      3'd2: group = {enables.ioJrst, enables.ac, irAc};
      3'd3: group = {dramA, dramB};
      3'd4: group = {testSatisfied, jrst0, dramJ[0:3]};
      3'd5: group = {1'b0, dramOddParity, dramJ[4:7]};
      3'd6: group = {adEq0, ioLegal, acEq0, isJrst, aGtB, adCarry};
      default: group = '0;
    endcase
  end

  // Read data follows the held address
  always_comb begin
    wbDatR = '0;
    if (ramSel) begin
      wbDatR = hostRData;
    end else if (groupSel) begin
      wbDatR[5:0] = group;
    end else if (enSel) begin
      wbDatR[1:0] = enables;
    end
  end

  singleAck: assert property (
    @(posedge eboxClk) disable iff (!rstN)
    wbAck |=> !wbAck
  );

endmodule

`default_nettype wire

//--- source/dispatchRam.sv
`timescale 1ns/1ps
`default_nettype none

module dispatchRam import irPkg::*; (
  input  wire        eboxClk,
  input  wire        rstN,
  input  wire instrT ir,
  input  wire        isJrst,
  input  wire irEnablesT enables,
  input  wire        loadDram,
  input  wire hostReqT host,
  output logic       hostGrant,
  output dramWordT   hostRData,
  output dramAddrT   dramAddr,
  output logic [0:2] dramA,
  output logic [0:2] dramB,
  output logic [0:7] dramJ,
  output logic       dramOddParity
);

  dramWordT mem [0:511];
  dramWordT dramWord;
  dramAddrT nextAddr;
  logic     instr7xx;
  logic     instr3to6;
  logic     lookupPending;

  // I/O fold applies to 7xx opcodes only when enabled
  assign instr7xx = (ir[0:2] == ioOpPrefix) && enables.ioJrst;
  assign instr3to6 = &ir[3:6];

  always_comb begin
    if (instr7xx) begin
      nextAddr = {ioOpPrefix, ir[7:9] | {3{instr3to6}}, ir[10:12]};
    end else begin
      nextAddr = ir[0:8];
    end
  end

  // Host gets the RAM only in cycles without a dispatch load
  assign hostGrant = host.req && !loadDram;

  // Host port accessed on the granting edge
  always_ff @(posedge eboxClk) begin
    if (hostGrant) begin
      if (host.we) begin
        mem[host.addr] <= host.wdata;
      end
      hostRData <= mem[host.addr];
    end
  end

  // Address at the load edge and word one edge later
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      dramAddr <= '0;
      lookupPending <= 1'b0;
      dramWord <= '0;
    end else begin
      lookupPending <= loadDram;
      if (loadDram) begin
        dramAddr <= nextAddr;
      end
      if (lookupPending) begin
        dramWord <= mem[dramAddr];
      end
    end
  end

  assign dramA = dramWord.a;
  assign dramB = dramWord.b;

  // JRST takes its low jump bits from the AC field
  assign dramJ = {dramWord.jHigh, isJrst ? ir[9:12] : dramWord.jLow};

  assign dramOddParity = ^dramWord;

  // A request held off by loadDram stays pending
  hostHeldOff: assert property (
    @(posedge eboxClk) disable iff (!rstN)
    (host.req && loadDram) |=> host.req
  );

endmodule

`default_nettype wire

//--- source/instrLatch.sv
`timescale 1ns/1ps
`default_nettype none

module instrLatch import irPkg::*; (
  input  wire        eboxClk,
  input  wire        rstN,
  input  wire word36T cacheData,
  input  wire adWordT ad,
  input  wire        mbXfer,
  input  wire        loadIr,
  input  wire irEnablesT enables,
  output instrT      ir,
  output acT         irAc,
  output logic       isJrst,
  output logic       jrst0,
  output logic       ioLegal,
  output logic       acEq0
);

  instrT newInstr;

  // Source select between adder and cache
  assign newInstr = mbXfer ? ad[0:12] : cacheData[0:12];

  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      ir <= '0;
      irAc <= '0;
    end else if (loadIr) begin
      ir <= newInstr;
      // AC register takes the field of the incoming instruction
      irAc <= enables.ac ? newInstr[9:12] : '0;
    end
  end

  // Decodes of the latched instruction
  assign isJrst = (ir[0:8] == jrstOpcode);
  assign acEq0 = (ir[9:12] == 4'b0000);
  assign jrst0 = isJrst && acEq0;
  assign ioLegal = &ir[3:6];

  loadIrKnown: assert property (
    @(posedge eboxClk) disable iff (!rstN)
    !$isunknown(loadIr)
  );

endmodule

`default_nettype wire

//--- source/irPkg.sv
`default_nettype none

package irPkg;

  // Machine bit order, bit 0 is the most significant
  typedef logic [0:35] word36T;

  // Adder output with two guard bits ahead of the data
  typedef logic [-2:35] adWordT;

  // Opcode 0..8 and AC 9..12
  typedef logic [0:12] instrT;

  typedef logic [0:3] acT;
  typedef logic [0:8] dramAddrT;
  typedef logic [0:2] normT;

  // Diagnostic group number and contents
  typedef logic [0:2] diagSelT;
  typedef logic [0:5] diagGroupT;

  // One dispatch RAM entry
  typedef struct packed {
    logic [0:2] a;
    logic [0:2] b;
    logic       par;
    logic [0:3] jHigh;
    logic [0:3] jLow;
  } dramWordT;

  // Diagnostic enables written by the host
  typedef struct packed {
    logic ioJrst;
    logic ac;
  } irEnablesT;

  // Host access to the dispatch RAM
  typedef struct packed {
    logic     req;
    logic     we;
    dramAddrT addr;
    dramWordT wdata;
  } hostReqT;

  // JRST opcode, octal 254
  localparam logic [0:8] jrstOpcode = 9'o254;

  // Top three opcode bits of an I/O instruction
  localparam logic [0:2] ioOpPrefix = 3'b111;

  // Wishbone word addresses
  localparam logic [9:0] diagBase = 10'h200;
  localparam logic [9:0] enableReg = 10'h208;

endpackage

`default_nettype wire

//--- source/irTop.sv
`timescale 1ns/1ps
`default_nettype none

module irTop import irPkg::*; (
  input  wire         eboxClk,
  input  wire         rstN,
  input  wire word36T cacheData,
  input  wire adWordT ad,
  input  wire         mbXfer,
  input  wire         loadIr,
  input  wire         loadDram,
  input  wire         adCarry,
  input  wire [0:1]   magic,
  input  wire         wbCyc,
  input  wire         wbStb,
  input  wire         wbWe,
  input  wire [9:0]   wbAdr,
  input  wire [14:0]  wbDatW,
  output logic [14:0] wbDatR,
  output logic        wbAck,
  output instrT       ir,
  output acT          irAc,
  output logic        adEq0,
  output logic        ioLegal,
  output logic        acEq0,
  output logic        jrst0,
  output logic        testSatisfied,
  output normT        norm,
  output logic [0:2]  dramA,
  output logic [0:2]  dramB,
  output logic [0:7]  dramJ,
  output logic        dramOddParity
);

  logic      isJrst;
  logic      aGtB;
  logic      hostGrant;
  irEnablesT enables;
  hostReqT   host;
  dramWordT  hostRData;
  dramAddrT  dramAddr;

  instrLatch instrLatch_inst (
    .eboxClk(eboxClk), .rstN(rstN), .cacheData(cacheData), .ad(ad),
    .mbXfer(mbXfer), .loadIr(loadIr), .enables(enables),
    .ir(ir), .irAc(irAc), .isJrst(isJrst), .jrst0(jrst0),
    .ioLegal(ioLegal), .acEq0(acEq0)
  );

  dispatchRam dispatchRam_inst (
    .eboxClk(eboxClk), .rstN(rstN), .ir(ir), .isJrst(isJrst),
    .enables(enables), .loadDram(loadDram), .host(host),
    .hostGrant(hostGrant), .hostRData(hostRData), .dramAddr(dramAddr),
    .dramA(dramA), .dramB(dramB), .dramJ(dramJ), .dramOddParity(dramOddParity)
  );

  adCondition adCondition_inst (
    .ad(ad), .adCarry(adCarry), .magic(magic), .dramB(dramB),
    .adEq0(adEq0), .aGtB(aGtB), .testSatisfied(testSatisfied), .norm(norm)
  );

  diagPort diagPort_inst (
    .eboxClk(eboxClk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb),
    .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
    .hostGrant(hostGrant), .hostRData(hostRData),
    .norm(norm), .dramAddr(dramAddr), .irAc(irAc),
    .dramA(dramA), .dramB(dramB), .dramJ(dramJ),
    .dramOddParity(dramOddParity), .testSatisfied(testSatisfied),
    .jrst0(jrst0), .isJrst(isJrst), .adEq0(adEq0), .ioLegal(ioLegal),
    .acEq0(acEq0), .aGtB(aGtB), .adCarry(adCarry),
    .wbDatR(wbDatR), .wbAck(wbAck), .host(host), .enables(enables)
  );

endmodule

`default_nettype wire

//--- verif/irTb.sv
`timescale 1ns/1ps
`default_nettype none

module irTb import irPkg::*; ();

  localparam int numVecs = 24;
  // RAM load and readback, then the table, then margin
  localparam int timeoutCycles = 512 * 8 + numVecs * 40 + 200;

  typedef struct {
    word36T     cache;
    adWordT     ad;
    logic       mbXfer;
    irEnablesT  en;
    logic       adCarry;
    logic [0:1] magic;
    instrT      expIr;
    acT         expAc;
    logic       expIsJrst;
    logic       expJrst0;
    logic       expIoLegal;
    logic       expAcEq0;
    dramAddrT   expAddr;
    logic [0:2] expA;
    logic [0:2] expB;
    logic [0:7] expJ;
    logic       expPar;
    logic       expEq0;
    logic       expGt;
    normT       expNorm;
    logic       expTest;
  } vecT;

  logic        eboxClk;
  logic        rstN;
  word36T      cacheData;
  adWordT      ad;
  logic        mbXfer, loadIr, loadDram, adCarry;
  logic [0:1]  magic;
  logic        wbCyc, wbStb, wbWe, wbAck;
  logic [9:0]  wbAdr;
  logic [14:0] wbDatW, wbDatR;
  instrT       ir;
  acT          irAc;
  logic        adEq0, ioLegal, acEq0, jrst0, testSatisfied, dramOddParity;
  normT        norm;
  logic [0:2]  dramA, dramB;
  logic [0:7]  dramJ;

  dramWordT shadow [0:511];
  vecT      vecs [0:numVecs-1];
  int       errors;
  int       checks;
  int       cycleCount;
  time      lastAckTime;

  irTop irTop_inst (.*);

  always #5 eboxClk = ~eboxClk;

  always @(posedge eboxClk) begin
    cycleCount++;
    if (cycleCount >= timeoutCycles) begin
      $display("timeout reached after %0d cycles, %0d errors so far", cycleCount, errors);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic checkValue(input string name, input logic [37:0] actual,
                            input logic [37:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error at time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic wbAccess(input logic we, input logic [9:0] adr, input logic [14:0] dat,
                          output logic [14:0] rdata);
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe = we;
    wbAdr = adr;
    wbDatW = dat;
    do begin
      @(posedge eboxClk);
      #1;
    end while (wbAck !== 1'b1);
    rdata = wbDatR;
    lastAckTime = $time;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    // Ack must be gone on the following cycle
    @(posedge eboxClk);
    #1;
    checkValue("wbAck", wbAck, 1'b0);
  endtask

  task automatic readGroup(input int num, input logic [5:0] expected);
    logic [14:0] rd;
    wbAccess(1'b0, diagBase + 10'(num), 15'd0, rd);
    checkValue($sformatf("group %0d", num), rd, expected);
  endtask

  function automatic dramAddrT dispatchAddr(instrT instr, logic ioJrst);
    if (instr[0:2] == 3'b111 && ioJrst) begin
      // Device field forced when bits 3..6 are all ones
      if (instr[3:6] == 4'b1111) begin
        return {3'b111, 3'b111, instr[10:12]};
      end
      return {3'b111, instr[7:9], instr[10:12]};
    end
    return instr[0:8];
  endfunction

  function automatic normT normCode(adWordT a);
    int first;
    first = -1;
    for (int i = 35; i >= 0; i--) begin
      if (a[i]) begin
        first = i;
      end
    end
    case (first)
      -1: return 3'd0;
      0: return 3'd1;
      1, 2, 3, 4, 5, 6: return 3'd2;
      7: return 3'd3;
      8: return 3'd4;
      9: return 3'd5;
      10: return 3'd6;
      default: return 3'd7;
    endcase
  endfunction

  function automatic logic skipCondition(adWordT a, logic carry, logic [0:1] m,
                                         logic [0:2] b);
    logic zero;
    logic gt;
    logic any;
    zero = (a == '0);
    gt = (a[0] != a[-2]);
    any = (b[1] && zero) || (b[2] && gt && m[0]) || (b[2] && a[0] && m[1]);
    any = any || ((m[0] == m[1]) && carry);
    return any != b[0];
  endfunction

  function automatic logic oddParity(dramWordT w);
    logic [14:0] bits;
    int ones;
    bits = w;
    ones = 0;
    for (int i = 0; i < 15; i++) begin
      ones += bits[i];
    end
    return ones % 2 == 1;
  endfunction

  task automatic buildTable();
    int onePos [0:7];
    vecT v;
    dramWordT w;
    // One-hot positions covering every normalize code
    onePos = '{0, 3, 7, 8, 9, 10, 20, 35};
    for (int i = 0; i < numVecs; i++) begin
      v.cache = 36'({$urandom(), $urandom()});
      v.ad = 38'({$urandom(), $urandom()});
      v.mbXfer = 1'b0;
      v.en = 2'($urandom());
      v.adCarry = 1'($urandom());
      v.magic = 2'($urandom());
      case (i)
        0: v.cache[0:12] = {jrstOpcode, 4'd0};
        1: begin
          v.mbXfer = 1'b1;
          v.ad[0:12] = {jrstOpcode, 4'd5};
        end
        2: begin
          v.cache[0:12] = {9'o776, 4'd3};
          v.en.ioJrst = 1'b1;
        end
        3: begin
          v.cache[0:12] = {9'o704, 4'd9};
          v.en.ioJrst = 1'b1;
        end
        4: begin
          v.cache[0:12] = {9'o776, 4'd3};
          v.en.ioJrst = 1'b0;
        end
        5: begin
          v.mbXfer = 1'b1;
          v.ad[0:12] = {9'o712, 4'd0};
          v.en = 2'b11;
        end
        default: ;
      endcase
      if (i >= 8 && i < 16) begin
        v.ad = '0;
        v.ad[onePos[i - 8]] = 1'b1;
        v.ad[-2] = 1'(i % 2);
      end else if (i == 16) begin
        v.ad = '0;
      end else if (i == 17) begin
        v.ad = '0;
        v.ad[-1] = 1'b1;
      end
      v.expIr = v.mbXfer ? v.ad[0:12] : v.cache[0:12];
      v.expAc = v.en.ac ? v.expIr[9:12] : 4'd0;
      v.expIsJrst = (v.expIr[0:8] == 9'o254);
      v.expAcEq0 = (v.expIr[9:12] == 4'd0);
      v.expJrst0 = v.expIsJrst && v.expAcEq0;
      v.expIoLegal = (v.expIr[3:6] == 4'b1111);
      v.expAddr = dispatchAddr(v.expIr, v.en.ioJrst);
      w = shadow[v.expAddr];
      v.expA = w.a;
      v.expB = w.b;
      v.expJ = {w.jHigh, v.expIsJrst ? v.expIr[9:12] : w.jLow};
      v.expPar = oddParity(w);
      v.expEq0 = (v.ad == '0);
      v.expGt = (v.ad[0] != v.ad[-2]);
      v.expNorm = normCode(v.ad);
      v.expTest = skipCondition(v.ad, v.adCarry, v.magic, w.b);
      vecs[i] = v;
    end
  endtask

  task automatic applyVector(input vecT v);
    logic [14:0] rd;
    wbAccess(1'b1, enableReg, 15'(v.en), rd);
    cacheData = v.cache;
    ad = v.ad;
    mbXfer = v.mbXfer;
    adCarry = v.adCarry;
    magic = v.magic;
    loadIr = 1'b1;
    @(posedge eboxClk);
    #1;
    loadIr = 1'b0;
    loadDram = 1'b1;
    @(posedge eboxClk);
    #1;
    loadDram = 1'b0;
    // Dispatch word is out after the second edge
    @(posedge eboxClk);
    #1;
    checkValue("ir", ir, v.expIr);
    checkValue("irAc", irAc, v.expAc);
    checkValue("jrst0", jrst0, v.expJrst0);
    checkValue("ioLegal", ioLegal, v.expIoLegal);
    checkValue("acEq0", acEq0, v.expAcEq0);
    checkValue("dramA", dramA, v.expA);
    checkValue("dramB", dramB, v.expB);
    checkValue("dramJ", dramJ, v.expJ);
    checkValue("dramOddParity", dramOddParity, v.expPar);
    checkValue("adEq0", adEq0, v.expEq0);
    checkValue("norm", norm, v.expNorm);
    checkValue("testSatisfied", testSatisfied, v.expTest);
    readGroup(0, {v.expNorm, v.expAddr[0:2]});
    readGroup(1, v.expAddr[3:8]);
    readGroup(2, {v.en.ioJrst, v.en.ac, v.expAc});
    readGroup(3, {v.expA, v.expB});
    readGroup(4, {v.expTest, v.expJrst0, v.expJ[0:3]});
    readGroup(5, {1'b0, v.expPar, v.expJ[4:7]});
    readGroup(6, {v.expEq0, v.expIoLegal, v.expAcEq0, v.expIsJrst, v.expGt, v.adCarry});
    readGroup(7, 6'd0);
    wbAccess(1'b0, enableReg, 15'd0, rd);
    checkValue("enables", rd, v.en);
  endtask

  initial begin
    logic [14:0] rd;
    dramAddrT bpAddr;
    dramWordT bpWord;
    time releaseTime;

    void'($urandom(22));
    errors = 0;
    checks = 0;
    cycleCount = 0;
    eboxClk = 1'b0;
    rstN = 1'b0;
    cacheData = '0;
    ad = '0;
    mbXfer = 1'b0;
    loadIr = 1'b0;
    loadDram = 1'b0;
    adCarry = 1'b0;
    magic = 2'b00;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = '0;
    wbDatW = '0;
    for (int a = 0; a < 512; a++) begin
      shadow[a] = 15'($urandom());
    end
    buildTable();
    repeat (10) @(posedge eboxClk);
    #1;
    rstN = 1'b1;

    checkValue("ir", ir, 13'd0);
    checkValue("dramJ", dramJ, 8'd0);
    wbAccess(1'b0, enableReg, 15'd0, rd);
    checkValue("enables", rd, 2'b00);

    // Full RAM load, then readback
    for (int a = 0; a < 512; a++) begin
      wbAccess(1'b1, 10'(a), 15'(shadow[a]), rd);
    end
    for (int a = 0; a < 512; a++) begin
      wbAccess(1'b0, 10'(a), 15'd0, rd);
      checkValue("wbDatR", rd, shadow[a]);
    end

    for (int i = 0; i < numVecs; i++) begin
      applyVector(vecs[i]);
    end

    // RAM write while loadDram is held high
    bpAddr = 9'd77;
    bpWord = 15'($urandom());
    fork
      wbAccess(1'b1, 10'(bpAddr), 15'(bpWord), rd);
      begin
        loadDram = 1'b1;
        repeat (6) @(posedge eboxClk);
        #1;
        loadDram = 1'b0;
        releaseTime = $time;
      end
    join
    checks++;
    if (lastAckTime <= releaseTime) begin
      errors++;
      $display("error at time %0t: RAM write acknowledged while loadDram was high",
               lastAckTime);
    end
    shadow[bpAddr] = bpWord;
    wbAccess(1'b0, 10'(bpAddr), 15'd0, rd);
    checkValue("wbDatR", rd, shadow[bpAddr]);

    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
